//--- design/branchCompare.sv
`timescale 1ns/1ns
`include "execUnit_settings.svh"

module branchCompare (
    input  execPkg::opE            opCode,
    input  logic [`EXEC_XLEN-1:0]  opA,
    input  logic [`EXEC_XLEN-1:0]  opB,
    output execPkg::cmpResT        cmpRes
);

    logic isEq;
    logic ltSigned;
    logic ltUnsigned;

    assign isEq       = (opA == opB);
    assign ltSigned   = ($signed(opA) < $signed(opB));
    assign ltUnsigned = (opA < opB);

    always_comb begin
        cmpRes.isCmp    = 1'b1;
        cmpRes.isBranch = 1'b1;
        cmpRes.met      = 1'b0;
        case (opCode)
            execPkg::OP_BEQ: begin
                cmpRes.met = isEq;
            end
            execPkg::OP_BNE: begin
                cmpRes.met = ~isEq;
            end
            execPkg::OP_BLT: begin
                cmpRes.met = ltSigned;
            end
            execPkg::OP_BGE: begin
                cmpRes.met = ~ltSigned; // Greater or equal
            end
            execPkg::OP_BLTU: begin
                cmpRes.met = ltUnsigned;
            end
            execPkg::OP_BGEU: begin
                cmpRes.met = ~ltUnsigned;
            end
            execPkg::OP_SLT: begin
                cmpRes.isBranch = 1'b0;
                cmpRes.met      = ltSigned;
            end
            execPkg::OP_SLTU: begin
                cmpRes.isBranch = 1'b0;
                cmpRes.met      = ltUnsigned;
            end
            default: begin
                cmpRes.isCmp    = 1'b0; // ALU opcode
                cmpRes.isBranch = 1'b0;
            end
        endcase
    end

endmodule

//--- design/execPkg.sv
`include "execUnit_settings.svh"

package execPkg;

    // Decoded opcode with the decoder's numbering
    typedef enum logic [3:0] {
        OP_BEQ  = 4'd0,
        OP_BNE  = 4'd1,
        OP_BLT  = 4'd2,
        OP_BGE  = 4'd3,
        OP_BLTU = 4'd4,
        OP_BGEU = 4'd5,
        OP_ADD  = 4'd6,
        OP_SUB  = 4'd7,
        OP_AND  = 4'd8,
        OP_SLT  = 4'd9,
        OP_SLTU = 4'd10,
        OP_OR   = 4'd11,
        OP_XOR  = 4'd12,
        OP_SLL  = 4'd13,
        OP_SRL  = 4'd14,
        OP_SRA  = 4'd15
    } opE;

    // Comparator result
    typedef struct packed {
        logic isCmp;    // Opcode handled by compare unit
        logic isBranch; // Branch without register write
        logic met;      // Condition holds
    } cmpResT;

    // ALU result with the operation tag
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  value;
        logic [`EXEC_TAG_W-1:0] tag;
    } aluResT;

endpackage

//--- design/execUnit.sv
`timescale 1ns/1ns
`include "execUnit_settings.svh"

module execUnit (
    input  logic                   soc_clk,
    input  logic                   rstN,
    input  logic                   opValid,
    output logic                   opReady,
    input  execPkg::opE            opCode,
    input  logic [`EXEC_XLEN-1:0]  opA,
    input  logic [`EXEC_XLEN-1:0]  opB,
    input  logic [`EXEC_TAG_W-1:0] opTag,
    output logic                   resValid,
    input  logic                   resReady,
    output logic [`EXEC_XLEN-1:0]  resData,
    output logic                   resTaken,
    output logic                   resWrite,
    output logic [`EXEC_TAG_W-1:0] resTag
);

    execPkg::cmpResT cmpRes;
    execPkg::aluResT aluRes;
    execPkg::cmpResT cmpStageRes;
    execPkg::aluResT aluStageRes;
    logic            cmpInReady;
    logic            aluInReady; // Mirrors cmpInReady
    logic            cmpOutValid;
    logic            aluOutValid;
    logic            cmpOutReady;
    logic            aluOutReady;

    assign opReady = cmpInReady; // Stages move in lockstep

    branchCompare cmpUnit (
        .opCode (opCode),
        .opA    (opA),
        .opB    (opB),
        .cmpRes (cmpRes)
    );

    intAlu aluUnit (
        .opCode (opCode),
        .opA    (opA),
        .opB    (opB),
        .opTag  (opTag),
        .aluRes (aluRes)
    );

    pipeStage #(.payloadT(execPkg::cmpResT)) cmpStage (
        .soc_clk  (soc_clk),
        .rstN     (rstN),
        .inValid  (opValid),
        .inReady  (cmpInReady),
        .inData   (cmpRes),
        .outValid (cmpOutValid),
        .outReady (cmpOutReady),
        .outData  (cmpStageRes)
    );

    pipeStage #(.payloadT(execPkg::aluResT)) aluStage (
        .soc_clk  (soc_clk),
        .rstN     (rstN),
        .inValid  (opValid),
        .inReady  (aluInReady),
        .inData   (aluRes),
        .outValid (aluOutValid),
        .outReady (aluOutReady),
        .outData  (aluStageRes)
    );

    resultMerge merge (
        .cmpValid (cmpOutValid),
        .cmpReady (cmpOutReady),
        .cmpRes   (cmpStageRes),
        .aluValid (aluOutValid),
        .aluReady (aluOutReady),
        .aluRes   (aluStageRes),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData),
        .resTaken (resTaken),
        .resWrite (resWrite),
        .resTag   (resTag)
    );

endmodule

//--- design/execUnit_settings.svh
`ifndef EXEC_UNIT_SETTINGS_SVH
`define EXEC_UNIT_SETTINGS_SVH

// Operand and result width of the integer datapath
`define EXEC_XLEN 32

// Width of the tag carried alongside each operation
`define EXEC_TAG_W 4

`endif

//--- design/intAlu.sv
`timescale 1ns/1ns
`include "execUnit_settings.svh"

module intAlu (
    input  execPkg::opE            opCode,
    input  logic [`EXEC_XLEN-1:0]  opA,
    input  logic [`EXEC_XLEN-1:0]  opB,
    input  logic [`EXEC_TAG_W-1:0] opTag,
    output execPkg::aluResT        aluRes
);

    logic [4:0]            shAmt;
    logic [`EXEC_XLEN-1:0] value;

    assign shAmt = opB[4:0]; // RV32 shift amount

    always_comb begin
        case (opCode)
            execPkg::OP_ADD: begin
                value = opA + opB;
            end
            execPkg::OP_SUB: begin
                value = opA - opB;
            end
            execPkg::OP_AND: begin
                value = opA & opB;
            end
            execPkg::OP_OR: begin
                value = opA | opB;
            end
            execPkg::OP_XOR: begin
                value = opA ^ opB;
            end
            execPkg::OP_SLL: begin
                value = opA << shAmt;
            end
            execPkg::OP_SRL: begin
                value = opA >> shAmt;
            end
            execPkg::OP_SRA: begin
                value = $unsigned($signed(opA) >>> shAmt); // Sign fill
            end
            default: begin
                value = '0; // Compare opcodes
            end
        endcase
    end

    assign aluRes.value = value;
    assign aluRes.tag   = opTag;

endmodule

//--- design/pipeStage.sv
`timescale 1ns/1ns

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    soc_clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    outValidR;
    logic    skidValidR;
    payloadT outDataR;
    payloadT skidDataR;
    logic    inFire;
    logic    loadOut;

    assign inReady  = ~skidValidR; // Straight from a flop
    assign inFire   = inValid & inReady;
    assign loadOut  = ~outValidR | outReady;
    assign outValid = outValidR;
    assign outData  = outDataR;

    always_ff @(posedge soc_clk or negedge rstN) begin
        if (!rstN) begin
            outValidR  <= 1'b0;
            skidValidR <= 1'b0;
        end else if (loadOut) begin
            if (skidValidR) begin
                outValidR  <= 1'b1; // Drain skid entry first
                skidValidR <= 1'b0;
            end else begin
                outValidR <= inFire;
            end
        end else if (inFire) begin
            skidValidR <= 1'b1; // Output held, park new item
        end
    end

    always_ff @(posedge soc_clk) begin
        if (loadOut) begin
            if (skidValidR) begin
                outDataR <= skidDataR;
            end else if (inFire) begin
                outDataR <= inData;
            end
        end else if (inFire) begin
            skidDataR <= inData;
        end
    end

endmodule

//--- design/resultMerge.sv
`timescale 1ns/1ns
`include "execUnit_settings.svh"

module resultMerge (
    input  logic                   cmpValid,
    output logic                   cmpReady,
    input  execPkg::cmpResT        cmpRes,
    input  logic                   aluValid,
    output logic                   aluReady,
    input  execPkg::aluResT        aluRes,
    output logic                   resValid,
    input  logic                   resReady,
    output logic [`EXEC_XLEN-1:0]  resData,
    output logic                   resTaken,
    output logic                   resWrite,
    output logic [`EXEC_TAG_W-1:0] resTag
);

    logic bothValid;
    logic popBoth;
    logic isBranchOp;
    logic isSetOp;

    assign bothValid = cmpValid & aluValid;
    assign popBoth   = bothValid & resReady; // Pop both stages in lockstep

    assign cmpReady = popBoth;
    assign aluReady = popBoth;
    assign resValid = bothValid;

    assign isBranchOp = cmpRes.isCmp & cmpRes.isBranch;
    assign isSetOp    = cmpRes.isCmp & ~cmpRes.isBranch;

    always_comb begin
        if (isBranchOp) begin
            resData = '0;
        end else if (isSetOp) begin
            resData = {{(`EXEC_XLEN-1){1'b0}}, cmpRes.met}; // SLT result
        end else begin
            resData = aluRes.value;
        end
    end

    assign resWrite = ~isBranchOp;
    assign resTaken = isBranchOp & cmpRes.met;
    assign resTag   = aluRes.tag;

endmodule

//--- execUnit.f
+incdir+design
design/execPkg.sv
design/pipeStage.sv
design/branchCompare.sv
design/intAlu.sv
design/resultMerge.sv
design/execUnit.sv
verif/execUnit_sva.sv
verif/execUnitChecker.sv
verif/execUnitTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f execUnit.f --top-module execUnitTb -o execUnitSim
./obj_dir/execUnitSim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

//--- verif/execUnitChecker.sv
`timescale 1ns/1ns
`include "execUnit_settings.svh"

module execUnitChecker (
    input  logic                   soc_clk,
    input  logic                   rstN,
    input  logic                   opValid,
    input  logic                   opReady,
    input  logic [3:0]             opCode,
    input  logic [`EXEC_XLEN-1:0]  opA,
    input  logic [`EXEC_XLEN-1:0]  opB,
    input  logic [`EXEC_TAG_W-1:0] opTag,
    input  logic                   resValid,
    input  logic                   resReady,
    input  logic [`EXEC_XLEN-1:0]  resData,
    input  logic                   resTaken,
    input  logic                   resWrite,
    input  logic [`EXEC_TAG_W-1:0] resTag,
    output int                     errorCount,
    output int                     pendingCount
);

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  data;
        logic                   taken;
        logic                   write;
        logic [`EXEC_TAG_W-1:0] tag;
    } expResT;

    expResT expQ[$];
    expResT expected;

    function automatic expResT modelResult(input logic [3:0] code,
                                           input logic [`EXEC_XLEN-1:0] a,
                                           input logic [`EXEC_XLEN-1:0] b,
                                           input logic [`EXEC_TAG_W-1:0] tag);
        expResT r;
        logic   lts;
        logic   ltu;
        lts     = $signed(a) < $signed(b);
        ltu     = a < b;
        r.data  = '0;
        r.taken = 1'b0;
        r.write = (code > 4'd5); // Codes 0 to 5 are branches
        r.tag   = tag;
        case (code)
            4'd0:  r.taken = (a == b);
            4'd1:  r.taken = (a != b);
            4'd2:  r.taken = lts;
            4'd3:  r.taken = ~lts;
            4'd4:  r.taken = ltu;
            4'd5:  r.taken = ~ltu;
            4'd6:  r.data = a + b;
            4'd7:  r.data = a - b;
            4'd8:  r.data = a & b;
            4'd9:  r.data = {{(`EXEC_XLEN-1){1'b0}}, lts};
            4'd10: r.data = {{(`EXEC_XLEN-1){1'b0}}, ltu};
            4'd11: r.data = a | b;
            4'd12: r.data = a ^ b;
            4'd13: r.data = a << b[4:0];
            4'd14: r.data = a >> b[4:0];
            default: r.data = $signed(a) >>> b[4:0];
        endcase
        return r;
    endfunction

    task automatic compareField(input string name, input logic [`EXEC_XLEN-1:0] want,
                                input logic [`EXEC_XLEN-1:0] got);
        if (want !== got) begin
            $display("Error at %0t ns: %s expected %h got %h", $time, name, want, got);
            errorCount = errorCount + 1;
        end
    endtask

    always @(posedge soc_clk or negedge rstN) begin
        if (!rstN) begin
            expQ.delete();
            errorCount = 0;
            pendingCount <= 0;
        end else begin
            if (resValid && resReady) begin
                if (expQ.size() == 0) begin
                    $display("Error at %0t ns: result delivered with no operation outstanding",
                             $time);
                    errorCount = errorCount + 1;
                end else begin
                    expected = expQ.pop_front();
                    compareField("resData", expected.data, resData);
                    compareField("resTaken", 32'(expected.taken), 32'(resTaken));
                    compareField("resWrite", 32'(expected.write), 32'(resWrite));
                    compareField("resTag", 32'(expected.tag), 32'(resTag));
                end
            end
            if (opValid && opReady) begin
                expQ.push_back(modelResult(opCode, opA, opB, opTag));
            end
            pendingCount <= expQ.size();
        end
    end

endmodule

//--- verif/execUnitTb.sv
`timescale 1ns/1ns
`include "execUnit_settings.svh"

module execUnitTb;

    localparam int NUM_OPS     = 2000;
    localparam int CYCLE_LIMIT = 4 * NUM_OPS + 100; // Worst case four cycles per operation

    logic                   soc_clk;
    logic                   rstN;
    logic                   opValid;
    logic                   opReady;
    execPkg::opE            opCode;
    logic [`EXEC_XLEN-1:0]  opA;
    logic [`EXEC_XLEN-1:0]  opB;
    logic [`EXEC_TAG_W-1:0] opTag;
    logic                   resValid;
    logic                   resReady;
    logic [`EXEC_XLEN-1:0]  resData;
    logic                   resTaken;
    logic                   resWrite;
    logic [`EXEC_TAG_W-1:0] resTag;
    integer                 seed = 32'hf87d;
    int                     cycleCount = 0;
    int                     acceptCount;
    int                     holdAccepts;
    int                     tbErrors;
    int                     checkErrors;
    int                     pendingCount;
    logic [31:0]            rnd;

    always #50 soc_clk = ~soc_clk;

    execUnit dut (
        .soc_clk  (soc_clk),
        .rstN     (rstN),
        .opValid  (opValid),
        .opReady  (opReady),
        .opCode   (opCode),
        .opA      (opA),
        .opB      (opB),
        .opTag    (opTag),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData),
        .resTaken (resTaken),
        .resWrite (resWrite),
        .resTag   (resTag)
    );

    execUnitChecker chk (
        .soc_clk      (soc_clk),
        .rstN         (rstN),
        .opValid      (opValid),
        .opReady      (opReady),
        .opCode       (opCode),
        .opA          (opA),
        .opB          (opB),
        .opTag        (opTag),
        .resValid     (resValid),
        .resReady     (resReady),
        .resData      (resData),
        .resTaken     (resTaken),
        .resWrite     (resWrite),
        .resTag       (resTag),
        .errorCount   (checkErrors),
        .pendingCount (pendingCount)
    );

    // Corner values show up often
    function automatic logic [`EXEC_XLEN-1:0] pickOperand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0: return 32'h7fff_ffff;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'hffff_ffff;
            3'd3: return 32'h0000_0000;
            default: return $random(seed);
        endcase
    endfunction

    task automatic drawOperation;
        logic [31:0]           r;
        logic [`EXEC_XLEN-1:0] a;
        r = $random(seed);
        opCode <= execPkg::opE'(r[3:0]);
        a = pickOperand();
        opA <= a;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            opB <= a; // Equal operands
        end else begin
            opB <= pickOperand();
        end
        r = $random(seed);
        opTag <= r[`EXEC_TAG_W-1:0];
    endtask

    task automatic verifyIdleAfterReset;
        if (resValid !== 1'b0) begin
            $display("Error at %0t ns: resValid expected 0 got %b", $time, resValid);
            tbErrors++;
        end
        if (opReady !== 1'b1) begin
            $display("Error at %0t ns: opReady expected 1 got %b", $time, opReady);
            tbErrors++;
        end
    endtask

    // Results held back, so only two operations fit
    task automatic fillWhileHeld;
        opValid <= 1'b1;
        drawOperation();
        repeat (8) begin
            @(posedge soc_clk);
            if (opValid && opReady) begin
                holdAccepts++;
                drawOperation();
            end
        end
        if (holdAccepts != 2) begin
            $display("Error at %0t ns: %0d operations accepted while results were held, %s",
                     $time, holdAccepts, "expected 2");
            tbErrors++;
        end
        if (opReady !== 1'b0) begin
            $display("Error at %0t ns: opReady expected 0 got %b", $time, opReady);
            tbErrors++;
        end
    endtask

    always @(posedge soc_clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d operations accepted, %0d results missing",
                     cycleCount, acceptCount, pendingCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        soc_clk     = 1'b0;
        rstN        = 1'b0;
        opValid     = 1'b0;
        opCode      = execPkg::OP_ADD;
        opA         = '0;
        opB         = '0;
        opTag       = '0;
        resReady    = 1'b0;
        acceptCount = 0;
        holdAccepts = 0;
        tbErrors    = 0;
        repeat (10) @(posedge soc_clk);
        rstN <= 1'b1;
        @(posedge soc_clk);
        verifyIdleAfterReset();
        fillWhileHeld();
        while (acceptCount < NUM_OPS) begin
            @(posedge soc_clk);
            if (opValid && opReady) begin
                acceptCount++;
            end
            rnd = $random(seed);
            resReady <= ((rnd % 100) < 60);
            if (acceptCount >= NUM_OPS) begin
                opValid <= 1'b0;
            end else if (!opValid || opReady) begin
                rnd = $random(seed);
                opValid <= ((rnd % 100) < 70);
                drawOperation();
            end
        end
        resReady <= 1'b1; // Drain what is left
        @(posedge soc_clk);
        while (pendingCount != 0) begin
            @(posedge soc_clk);
        end
        $display("Errors: %0d from checker, %0d from testbench", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verif/execUnit_sva.sv
`timescale 1ns/1ns
`include "execUnit_settings.svh"

module execUnitSva (
    input logic                   soc_clk,
    input logic                   rstN,
    input logic                   opValid,
    input logic                   opReady,
    input logic [3:0]             opCode,
    input logic [`EXEC_XLEN-1:0]  opA,
    input logic [`EXEC_XLEN-1:0]  opB,
    input logic [`EXEC_TAG_W-1:0] opTag,
    input logic                   resValid,
    input logic                   resReady,
    input logic [`EXEC_XLEN-1:0]  resData,
    input logic                   resTaken,
    input logic                   resWrite,
    input logic [`EXEC_TAG_W-1:0] resTag,
    input logic                   cmpInReady,
    input logic                   aluInReady
);

    assert property (@(posedge soc_clk) disable iff (!rstN)
        opValid && !opReady |=> opValid && $stable({opCode, opA, opB, opTag}))
        else $error("Operation changed while waiting for opReady");

    assert property (@(posedge soc_clk) disable iff (!rstN)
        resValid && !resReady |=> resValid && $stable({resData, resTaken, resWrite, resTag}))
        else $error("Result changed while waiting for resReady");

    // Both stages must fill and drain together
    assert property (@(posedge soc_clk) cmpInReady == aluInReady)
        else $error("Stage inReady signals differ");

    assert property (@(posedge soc_clk) !rstN |-> !resValid)
        else $error("resValid high during reset");

endmodule

bind execUnit execUnitSva sva (
    .soc_clk    (soc_clk),
    .rstN       (rstN),
    .opValid    (opValid),
    .opReady    (opReady),
    .opCode     (opCode),
    .opA        (opA),
    .opB        (opB),
    .opTag      (opTag),
    .resValid   (resValid),
    .resReady   (resReady),
    .resData    (resData),
    .resTaken   (resTaken),
    .resWrite   (resWrite),
    .resTag     (resTag),
    .cmpInReady (cmpInReady),
    .aluInReady (aluInReady)
);
